// File: hw/regs_pkg.sv
// ********************
// register write-back types
// ********************
`default_nettype none

package regs_pkg;

   // ********************
   // register sizes
   // ********************
   localparam int reg_addr_w  = 5;
   localparam int reg_count   = 32;
   localparam int data_w      = 32;
   localparam int queue_depth = 3;

   // one write-back entry, 39 bits
   typedef struct packed {
      logic                  valid;
      // high selects the float bank
      logic                  float;
      logic [reg_addr_w-1:0] addr;
      logic [data_w-1:0]     data;
   } wb_entry_t;

   // ********************
   // forwarding source
   // ********************
   // 0..2 name a queue stage, 3 the register file
   typedef logic [1:0] fwd_pos_t;

   localparam fwd_pos_t fwd_stage0 = 2'd0;
   localparam fwd_pos_t fwd_stage1 = 2'd1;
   localparam fwd_pos_t fwd_stage2 = 2'd2;
   localparam fwd_pos_t fwd_file   = 2'd3;

endpackage : regs_pkg

`default_nettype wire

// File: hw/writeback_queue_stage.sv
// ********************
// write-back queue stage
// ********************
`timescale 1ns/100ps
`default_nettype none

module writeback_queue_stage
   import regs_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst_n,
   // entry moving down the chain
   input  wire wb_entry_t up,
   // entry from the local unit
   input  wire wb_entry_t side,
   output wb_entry_t      down
);

   wb_entry_t next_entry;

   // upstream wins, the scheduler keeps both from being valid
   always_comb begin
      if (up.valid) begin
         next_entry = up;
      end else begin
         next_entry = side;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      down.float <= next_entry.float;
      down.addr  <= next_entry.addr;
      down.data  <= next_entry.data;
   end

   // valid bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         down.valid <= 1'b0;
      end else begin
         down.valid <= next_entry.valid;
      end
   end

endmodule : writeback_queue_stage

`default_nettype wire

// File: hw/register_file.sv
// ********************
// 32 x 32 register file
// ********************
`timescale 1ns/100ps
`default_nettype none

module register_file
   import regs_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic [reg_addr_w-1:0] rs_addr,
   input  wire logic [reg_addr_w-1:0] rt_addr,
   output logic      [data_w-1:0]     rs_data,
   output logic      [data_w-1:0]     rt_data,
   // valid is already masked per bank
   input  wire wb_entry_t             write
);

   logic [data_w-1:0] regs [reg_count];

   // ********************
   // read ports
   // ********************
   // combinational, the top registers the result
   always_comb begin
      rs_data = regs[rs_addr];
   end

   always_comb begin
      rt_data = regs[rt_addr];
   end

   // ********************
   // write port
   // ********************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (write.valid) begin
         regs[write.addr] <= write.data;
      end
   end

endmodule : register_file

`default_nettype wire

// File: hw/forward_select.sv
// ********************
// forwarding source select
// ********************
`timescale 1ns/100ps
`default_nettype none

module forward_select
   import regs_pkg::*;
(
   input  wire logic [reg_addr_w-1:0] addr,
   input  wire logic                  float,
   input  wire wb_entry_t             stage0,
   input  wire wb_entry_t             stage1,
   input  wire wb_entry_t             stage2,
   output fwd_pos_t                   position
);

   logic hit0;
   logic hit1;
   logic hit2;

   // same register in the same bank, and the entry is live
   function automatic logic entry_hit(
      input wb_entry_t             entry,
      input logic [reg_addr_w-1:0] req_addr,
      input logic                  req_float
   );
      logic same_reg;
      same_reg = (entry.addr == req_addr) && (entry.float == req_float);
      return entry.valid && same_reg;
   endfunction

   always_comb begin
      hit0 = entry_hit(stage0, addr, float);
      hit1 = entry_hit(stage1, addr, float);
      hit2 = entry_hit(stage2, addr, float);
   end

   // stage 2 holds the youngest entry
   always_comb begin
      if (hit2) begin
         position = fwd_stage2;
      end else if (hit1) begin
         position = fwd_stage1;
      end else if (hit0) begin
         position = fwd_stage0;
      end else begin
         position = fwd_file;
      end
   end

endmodule : forward_select

`default_nettype wire

// File: hw/register_manager.sv
// ********************
// register manager
// write-back queue, banks and read forwarding
// ********************
`timescale 1ns/100ps
`default_nettype none

module register_manager
   import regs_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   // unit write-back strobes
   input  wire wb_entry_t             misc_wb,
   input  wire wb_entry_t             alu_wb,
   input  wire wb_entry_t             mem_wb,
   input  wire wb_entry_t             fpu_wb,
   // read ports
   input  wire logic [reg_addr_w-1:0] rs_addr,
   input  wire logic                  rs_float,
   input  wire logic [reg_addr_w-1:0] rt_addr,
   input  wire logic                  rt_float,
   output logic      [data_w-1:0]     rs_data,
   output logic      [data_w-1:0]     rt_data
);

   // index 0 is the oldest stage
   wb_entry_t stage_q    [queue_depth];
   wb_entry_t stage_up   [queue_depth];
   wb_entry_t stage_side [queue_depth];

   wb_entry_t int_write;
   wb_entry_t float_write;

   logic [data_w-1:0] int_rs_data;
   logic [data_w-1:0] int_rt_data;
   logic [data_w-1:0] float_rs_data;
   logic [data_w-1:0] float_rt_data;

   fwd_pos_t rs_position;
   fwd_pos_t rt_position;

   logic [data_w-1:0] raw_rs_data;
   logic [data_w-1:0] raw_rt_data;

   // ********************
   // write-back queue
   // ********************
   // misc enters stage 2 from the top, alu/mem/fpu at the side
   always_comb begin
      stage_side[0] = fpu_wb;
      stage_side[1] = mem_wb;
      stage_side[2] = alu_wb;
      stage_up[queue_depth-1] = misc_wb;
      for (int i = 0; i < queue_depth - 1; i++) begin
         stage_up[i] = stage_q[i+1];
      end
   end

   for (genvar i = 0; i < queue_depth; i++) begin : g_stage
      writeback_queue_stage stage (
         .clk   (clk),
         .rst_n (rst_n),
         .up    (stage_up[i]),
         .side  (stage_side[i]),
         .down  (stage_q[i])
      );
   end

   // ********************
   // bank steering
   // ********************
   always_comb begin
      int_write         = stage_q[0];
      float_write       = stage_q[0];
      int_write.valid   = stage_q[0].valid && !stage_q[0].float;
      float_write.valid = stage_q[0].valid && stage_q[0].float;
   end

   register_file int_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs_addr (rs_addr),
      .rt_addr (rt_addr),
      .rs_data (int_rs_data),
      .rt_data (int_rt_data),
      .write   (int_write)
   );

   register_file float_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs_addr (rs_addr),
      .rt_addr (rt_addr),
      .rs_data (float_rs_data),
      .rt_data (float_rt_data),
      .write   (float_write)
   );

   // ********************
   // forwarding
   // ********************
   forward_select fwd_rs (
      .addr     (rs_addr),
      .float    (rs_float),
      .stage0   (stage_q[0]),
      .stage1   (stage_q[1]),
      .stage2   (stage_q[2]),
      .position (rs_position)
   );

   forward_select fwd_rt (
      .addr     (rt_addr),
      .float    (rt_float),
      .stage0   (stage_q[0]),
      .stage1   (stage_q[1]),
      .stage2   (stage_q[2]),
      .position (rt_position)
   );

   function automatic logic [data_w-1:0] pick_data(
      input fwd_pos_t          pos,
      input logic              bank_float,
      input logic [data_w-1:0] int_d,
      input logic [data_w-1:0] float_d,
      input logic [data_w-1:0] s0_d,
      input logic [data_w-1:0] s1_d,
      input logic [data_w-1:0] s2_d
   );
      logic [data_w-1:0] result;
      case (pos)
         fwd_stage0: result = s0_d;
         fwd_stage1: result = s1_d;
         fwd_stage2: result = s2_d;
         default:    result = bank_float ? float_d : int_d;
      endcase
      return result;
   endfunction

   always_comb begin
      raw_rs_data = pick_data(rs_position, rs_float, int_rs_data, float_rs_data,
                              stage_q[0].data, stage_q[1].data, stage_q[2].data);
      raw_rt_data = pick_data(rt_position, rt_float, int_rt_data, float_rt_data,
                              stage_q[0].data, stage_q[1].data, stage_q[2].data);
   end

   // one cycle from address to data
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rs_data <= '0;
         rt_data <= '0;
      end else begin
         rs_data <= raw_rs_data;
         rt_data <= raw_rt_data;
      end
   end

endmodule : register_manager

`default_nettype wire

// File: verif/register_manager_assert.sv
// ********************
// register manager assertions
// ********************
`timescale 1ns/100ps
`default_nettype none

module register_manager_assert
   import regs_pkg::*;
(
   input wire logic                   clk,
   input wire logic                   rst_n,
   input wire wb_entry_t              misc_wb,
   input wire wb_entry_t              alu_wb,
   input wire wb_entry_t              mem_wb,
   input wire wb_entry_t              fpu_wb,
   // bit i is queue stage i
   input wire logic [queue_depth-1:0] stage_valid,
   // float bank in bit 1
   input wire logic [1:0]             bank_we,
   input wire logic [data_w-1:0]      rs_data,
   input wire logic [data_w-1:0]      rt_data,
   input wire logic [data_w-1:0]      exp_rs_data,
   input wire logic [data_w-1:0]      exp_rt_data,
   input wire logic [8*16-1:0]        test_name
);

   int fail_count = 0;

   // at most one valid entry into each stage
   queue_collision: assert property (@(posedge clk) disable iff (!rst_n)
      !(misc_wb.valid && alu_wb.valid) &&
      !(stage_valid[2] && mem_wb.valid) &&
      !(stage_valid[1] && fpu_wb.valid))
      else begin
         $error("two valid writes into one queue stage in test %0s", test_name);
         fail_count++;
      end

   rs_value: assert property (@(posedge clk) disable iff (!rst_n) rs_data == exp_rs_data)
      else begin
         $error("Mismatch rs_data in test %0s: expected %h, actual %h",
                test_name, $sampled(exp_rs_data), $sampled(rs_data));
         fail_count++;
      end

   rt_value: assert property (@(posedge clk) disable iff (!rst_n) rt_data == exp_rt_data)
      else begin
         $error("Mismatch rt_data in test %0s: expected %h, actual %h",
                test_name, $sampled(exp_rt_data), $sampled(rt_data));
         fail_count++;
      end

   // everything clear one cycle after a reset edge
   reset_state: assert property (@(posedge clk)
      !rst_n |=> rs_data == '0 && rt_data == '0 && stage_valid == '0 && bank_we == '0)
      else begin
         $error("read data or queue not cleared after reset in test %0s", test_name);
         fail_count++;
      end

endmodule : register_manager_assert

`default_nettype wire

// File: verif/tb_register_manager.sv
// ********************
// register manager testbench
// ********************
`timescale 1ns/100ps
`default_nettype none

module tb_register_manager
   import regs_pkg::*;
();

   localparam int clk_period    = 20;
   localparam int reset_cycles  = 16;
   localparam int flush_cycles  = 4;
   localparam int random_cycles = 400;
   // reset, banks, stages, youngest and random tests, each with a flush
   localparam int total_cycles  = reset_cycles + 2 * reg_count + 10 + 24 + 16
                                  + random_cycles + 5 * flush_cycles;
   localparam int watchdog_ns   = (total_cycles + 100) * clk_period;

   // everything the DUT samples at one edge
   typedef struct packed {
      logic                  rst_n;
      wb_entry_t             misc;
      wb_entry_t             alu;
      wb_entry_t             mem;
      wb_entry_t             fpu;
      logic [reg_addr_w-1:0] rs_addr;
      logic                  rs_float;
      logic [reg_addr_w-1:0] rt_addr;
      logic                  rt_float;
   } stim_t;

   stim_t             nxt;
   stim_t             drv;
   logic              clk;
   logic [data_w-1:0] rs_data;
   logic [data_w-1:0] rt_data;
   logic [data_w-1:0] exp_rs_data;
   logic [data_w-1:0] exp_rt_data;
   logic [8*16-1:0]   test_name;
   wb_entry_t         shadow_q [queue_depth];
   logic [data_w-1:0] shadow_bank [2][reg_count];
   int                start_fails;
   int                failed_tests;

   register_manager uut (
      .clk      (clk),
      .rst_n    (drv.rst_n),
      .misc_wb  (drv.misc),
      .alu_wb   (drv.alu),
      .mem_wb   (drv.mem),
      .fpu_wb   (drv.fpu),
      .rs_addr  (drv.rs_addr),
      .rs_float (drv.rs_float),
      .rt_addr  (drv.rt_addr),
      .rt_float (drv.rt_float),
      .rs_data  (rs_data),
      .rt_data  (rt_data)
   );

   bind register_manager register_manager_assert checks (
      .clk         (clk),
      .rst_n       (rst_n),
      .misc_wb     (misc_wb),
      .alu_wb      (alu_wb),
      .mem_wb      (mem_wb),
      .fpu_wb      (fpu_wb),
      .stage_valid ({stage_q[2].valid, stage_q[1].valid, stage_q[0].valid}),
      .bank_we     ({float_write.valid, int_write.valid}),
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .exp_rs_data (tb_register_manager.exp_rs_data),
      .exp_rt_data (tb_register_manager.exp_rt_data),
      .test_name   (tb_register_manager.test_name)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
      $display("TB FAILED");
      $finish;
   end

   // ********************
   // reference model
   // ********************
   // youngest matching queue entry, else the bank
   function automatic logic [data_w-1:0] expected_read(
      input logic [reg_addr_w-1:0] reg_a,
      input logic                  bank
   );
      logic [data_w-1:0] value;
      value = shadow_bank[bank][reg_a];
      for (int i = 0; i < queue_depth; i++) begin
         if (shadow_q[i].valid && shadow_q[i].addr == reg_a && shadow_q[i].float == bank) begin
            value = shadow_q[i].data;
         end
      end
      return value;
   endfunction

   task automatic model_edge();
      if (!drv.rst_n) begin
         for (int i = 0; i < queue_depth; i++) begin
            shadow_q[i] = '0;
         end
         for (int r = 0; r < reg_count; r++) begin
            shadow_bank[0][r] = '0;
            shadow_bank[1][r] = '0;
         end
         exp_rs_data <= '0;
         exp_rt_data <= '0;
      end else begin
         exp_rs_data <= expected_read(drv.rs_addr, drv.rs_float);
         exp_rt_data <= expected_read(drv.rt_addr, drv.rt_float);
         if (shadow_q[0].valid) begin
            shadow_bank[shadow_q[0].float][shadow_q[0].addr] = shadow_q[0].data;
         end
         // each stage prefers the entry moving down
         shadow_q[0] = shadow_q[1].valid ? shadow_q[1] : drv.fpu;
         shadow_q[1] = shadow_q[2].valid ? shadow_q[2] : drv.mem;
         shadow_q[2] = drv.misc.valid ? drv.misc : drv.alu;
      end
   endtask

   // ********************
   // stimulus helpers
   // ********************
   function automatic wb_entry_t make_entry(
      input logic                  bank,
      input logic [reg_addr_w-1:0] reg_a,
      input logic [data_w-1:0]     value
   );
      return '{valid: 1'b1, float: bank, addr: reg_a, data: value};
   endfunction

   // small address range so reads often hit the queue
   function automatic wb_entry_t random_entry();
      return make_entry(1'($urandom_range(0, 1)), reg_addr_w'($urandom_range(0, 7)), $urandom);
   endfunction

   task automatic drive_cycle();
      @(posedge clk);
      model_edge();
      drv <= nxt;
   endtask

   task automatic clear_writes();
      nxt.misc = '0;
      nxt.alu  = '0;
      nxt.mem  = '0;
      nxt.fpu  = '0;
   endtask

   task automatic idle(input int cycles);
      clear_writes();
      repeat (cycles) drive_cycle();
   endtask

   task automatic set_reads(
      input logic [reg_addr_w-1:0] rs_a,
      input logic                  rs_f,
      input logic [reg_addr_w-1:0] rt_a,
      input logic                  rt_f
   );
      nxt.rs_addr  = rs_a;
      nxt.rs_float = rs_f;
      nxt.rt_addr  = rt_a;
      nxt.rt_float = rt_f;
   endtask

   task automatic start_test(input logic [8*16-1:0] name);
      test_name   = name;
      start_fails = uut.checks.fail_count;
   endtask

   task automatic finish_test();
      int fails;
      idle(flush_cycles);
      @(negedge clk);
      fails = uut.checks.fail_count - start_fails;
      if (fails != 0) begin
         failed_tests++;
      end
      $display("test %0s done, %0d assertion failures", test_name, fails);
   endtask

   // ********************
   // tests
   // ********************
   initial begin
      wb_entry_t entry;
      logic      busy1;
      logic      busy2;
      drv = '0;
      nxt = '0;
      failed_tests = 0;
      void'($urandom(32'hee08));

      start_test("reset");
      idle(reset_cycles);
      nxt.rst_n = 1'b1;
      for (int pass = 0; pass < 2; pass++) begin
         for (int r = 0; r < reg_count; r++) begin
            set_reads(reg_addr_w'(r), 1'(pass), reg_addr_w'(reg_count - 1 - r), !1'(pass));
            drive_cycle();
         end
      end
      finish_test();

      start_test("bank separation");
      set_reads(5'd5, 1'b0, 5'd5, 1'b1);
      nxt.fpu = make_entry(1'b0, 5'd5, 32'h1111_0005);
      drive_cycle();
      nxt.fpu = make_entry(1'b1, 5'd5, 32'h2222_0005);
      drive_cycle();
      idle(8);
      finish_test();

      start_test("stage forwarding");
      for (int unit = 0; unit < 4; unit++) begin
         entry = make_entry(1'(unit), reg_addr_w'(8 + unit), $urandom);
         set_reads(entry.addr, entry.float, entry.addr, !entry.float);
         case (unit)
            0:       nxt.misc = entry;
            1:       nxt.alu  = entry;
            2:       nxt.mem  = entry;
            default: nxt.fpu  = entry;
         endcase
         drive_cycle();
         idle(5);
      end
      finish_test();

      start_test("youngest wins");
      // gap 0 issues both together, gap 1 issues misc a cycle after mem
      for (int gap = 0; gap < 2; gap++) begin
         set_reads(reg_addr_w'(20 + gap), 1'b0, reg_addr_w'(20 + gap), 1'b1);
         nxt.mem = make_entry(1'b0, reg_addr_w'(20 + gap), 32'hdead_0000);
         if (gap == 0) begin
            nxt.misc = make_entry(1'b0, reg_addr_w'(20 + gap), 32'hbeef_0000);
         end
         drive_cycle();
         clear_writes();
         if (gap == 1) begin
            nxt.misc = make_entry(1'b0, reg_addr_w'(20 + gap), 32'hbeef_0001);
         end
         drive_cycle();
         idle(6);
      end
      finish_test();

      start_test("random traffic");
      for (int n = 0; n < random_cycles; n++) begin
         // stages 2 and 1 as they stand when these inputs get sampled
         busy2 = nxt.misc.valid || nxt.alu.valid;
         busy1 = shadow_q[2].valid || nxt.mem.valid;
         clear_writes();
         if ($urandom_range(0, 3) == 0) begin
            nxt.misc = random_entry();
         end else if ($urandom_range(0, 2) == 0) begin
            nxt.alu = random_entry();
         end
         if (!busy2 && $urandom_range(0, 2) == 0) begin
            nxt.mem = random_entry();
         end
         if (!busy1 && $urandom_range(0, 2) == 0) begin
            nxt.fpu = random_entry();
         end
         set_reads(reg_addr_w'($urandom_range(0, 7)), 1'($urandom_range(0, 1)),
                   reg_addr_w'($urandom_range(0, 7)), 1'($urandom_range(0, 1)));
         drive_cycle();
      end
      finish_test();

      $display("%0d of 5 tests failed, %0d assertion failures in total",
               failed_tests, uut.checks.fail_count);
      if (failed_tests == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule : tb_register_manager

`default_nettype wire

// File: build.f
hw/regs_pkg.sv
hw/writeback_queue_stage.sv
hw/register_file.sv
hw/forward_select.sv
hw/register_manager.sv
verif/register_manager_assert.sv
verif/tb_register_manager.sv
